//--- source/flowPkg.sv
`default_nettype none

// shared types for the control-flow block of the rv32i core
package flowPkg;

  // one instruction address or one data word
  typedef logic [31:0] addressT;

  // size of one sequential address increment
  // rv32i without compressed instructions
  localparam addressT instructionStep = 32'd4;

  // control-flow class of one instruction
  typedef enum logic [2:0] {
    // plain fall-through, also used for unknown opcodes
    flowSeq    = 3'd0,
    // pc-relative jump and link
    flowJal    = 3'd1,
    // register-relative jump and link
    flowJalr   = 3'd2,
    // conditional pc-relative branch
    flowBranch = 3'd3,
    // add upper immediate to pc
    flowAuipc  = 3'd4
  } flowKindE;

  // decoder output, one per instruction
  typedef struct packed {
    // control-flow class
    flowKindE kind;
    // sign-extended immediate in the format the kind needs
    addressT  immediate;
    // branch condition select, passed straight through
    logic [2:0] funct3;
  } decodeT;

  // source register values that come with the instruction
  typedef struct packed {
    // base for jalr, left side of a branch compare
    addressT rs1Value;
    // right side of a branch compare
    addressT rs2Value;
  } operandT;

  // everything the counter drives out
  typedef struct packed {
    // address of the instruction being executed
    addressT instructionAddress;
    // return address for jal/jalr, pc plus offset for auipc
    addressT linkAddress;
    // high when linkAddress is meant for the destination register
    logic    linkValid;
  } resultT;

endpackage : flowPkg

`default_nettype wire

//--- source/immediateDecoder.sv
`timescale 1ns/1ps
`default_nettype none

// classifies one instruction word and builds its immediate
module immediateDecoder import flowPkg::*; (
  input  logic [31:0] instruction,
  output decodeT      decode
);

  // major opcodes this block cares about
  localparam logic [6:0] opcodeJal    = 7'b1101111;
  localparam logic [6:0] opcodeJalr   = 7'b1100111;
  localparam logic [6:0] opcodeBranch = 7'b1100011;
  localparam logic [6:0] opcodeAuipc  = 7'b0010111;

  logic [6:0] opcode;
  flowKindE   kind;

  // all four immediate formats, built side by side
  addressT immI;
  addressT immB;
  addressT immU;
  addressT immJ;
  addressT immediate;

  assign opcode = instruction[6:0];

  // opcode to control-flow class
  always_comb begin
    case (opcode)
      opcodeJal: begin
        kind = flowJal;
      end
      opcodeJalr: begin
        kind = flowJalr;
      end
      opcodeBranch: begin
        kind = flowBranch;
      end
      opcodeAuipc: begin
        kind = flowAuipc;
      end
      default: begin
        // alu, loads, stores and anything unknown fall through
        kind = flowSeq;
      end
    endcase
  end

  // i-type, 12 bits straight from the top of the word
  assign immI = {{20{instruction[31]}}, instruction[31:20]};

  // b-type, scrambled 12-bit offset in units of two bytes
  assign immB = {
    {19{instruction[31]}},
    instruction[31],
    instruction[7],
    instruction[30:25],
    instruction[11:8],
    1'b0
  };

  // u-type, upper 20 bits with zero low part
  assign immU = {instruction[31:12], 12'b0};

  // j-type, scrambled 20-bit offset in units of two bytes
  assign immJ = {
    {11{instruction[31]}},
    instruction[31],
    instruction[19:12],
    instruction[20],
    instruction[30:21],
    1'b0
  };

  // pick the format for the kind
  always_comb begin
    case (kind)
      flowJal: begin
        immediate = immJ;
      end
      flowJalr: begin
        immediate = immI;
      end
      flowBranch: begin
        immediate = immB;
      end
      flowAuipc: begin
        immediate = immU;
      end
      default: begin
        // sequential flow needs no offset
        immediate = '0;
      end
    endcase
  end

  // funct3 only matters for branches, but is passed through always
  assign decode = '{
    kind:      kind,
    immediate: immediate,
    funct3:    instruction[14:12]
  };

endmodule : immediateDecoder

`default_nettype wire

//--- source/branchComparator.sv
`timescale 1ns/1ps
`default_nettype none

// evaluates the rv32i branch condition selected by funct3
module branchComparator import flowPkg::*; (
  input  logic [2:0] funct3,
  input  operandT    operands,
  output logic       branchTaken
);

  logic isEqual;
  logic isLessSigned;
  logic isLessUnsigned;

  // one compare of each flavour, the rest are inversions
  assign isEqual        = operands.rs1Value == operands.rs2Value;
  assign isLessSigned   = $signed(operands.rs1Value) < $signed(operands.rs2Value);
  assign isLessUnsigned = operands.rs1Value < operands.rs2Value;

  always_comb begin
    case (funct3)
      // beq
      3'b000: begin
        branchTaken = isEqual;
      end
      // bne
      3'b001: begin
        branchTaken = !isEqual;
      end
      // blt
      3'b100: begin
        branchTaken = isLessSigned;
      end
      // bge
      3'b101: begin
        branchTaken = !isLessSigned;
      end
      // bltu
      3'b110: begin
        branchTaken = isLessUnsigned;
      end
      // bgeu
      3'b111: begin
        branchTaken = !isLessUnsigned;
      end
      default: begin
        // 010 and 011 are reserved, never taken
        branchTaken = 1'b0;
      end
    endcase
  end

endmodule : branchComparator

`default_nettype wire

//--- source/programCounter.sv
`timescale 1ns/1ps
`default_nettype none

// instruction address register plus next-address and link logic
module programCounter import flowPkg::*; #(
  parameter addressT resetVector = '0
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    step,
  input  decodeT  decode,
  input  logic    branchTaken,
  input  addressT rs1Value,
  output resultT  result
);

  addressT currentAddress;
  addressT nextAddress;
  addressT sequentialAddress;
  addressT relativeTarget;
  addressT registerTarget;
  addressT linkAddress;
  logic    linkValid;

  // candidate targets
  assign sequentialAddress = currentAddress + instructionStep;
  assign relativeTarget    = currentAddress + decode.immediate;
  // jalr drops bit 0 of the sum
  assign registerTarget    = {rs1Value[31:1] + decode.immediate[31:1] +
                              31'(rs1Value[0] & decode.immediate[0]), 1'b0};

  // next address by kind
  always_comb begin
    case (decode.kind)
      flowJal: begin
        nextAddress = relativeTarget;
      end
      flowJalr: begin
        nextAddress = registerTarget;
      end
      flowBranch: begin
        // not taken falls through
        nextAddress = branchTaken ? relativeTarget : sequentialAddress;
      end
      default: begin
        nextAddress = sequentialAddress;
      end
    endcase
  end

  // address moves only on a step
  always_ff @(posedge clk) begin
    if (reset) begin
      currentAddress <= resetVector;
    end else if (step) begin
      currentAddress <= nextAddress;
    end
  end

  // link value straight from the current address and kind
  always_comb begin
    case (decode.kind)
      flowJal, flowJalr: begin
        linkAddress = sequentialAddress;
        linkValid   = 1'b1;
      end
      flowAuipc: begin
        // u immediate already shifted up by the decoder
        linkAddress = relativeTarget;
        linkValid   = 1'b1;
      end
      default: begin
        linkAddress = '0;
        linkValid   = 1'b0;
      end
    endcase
  end

  assign result = '{
    instructionAddress: currentAddress,
    linkAddress:        linkAddress,
    linkValid:          linkValid
  };

  // jalr target lands on an even address
  jalrTargetEven: assert property (@(posedge clk) disable iff (reset)
    step && decode.kind == flowJalr |=> !currentAddress[0])
    else $error("jalr left an odd instruction address");

  // branches never carry a reserved funct3
  branchFunct3Legal: assert property (@(posedge clk) disable iff (reset)
    step && decode.kind == flowBranch |-> !(decode.funct3 inside {3'b010, 3'b011}))
    else $error("branch step with reserved funct3 %b", decode.funct3);

  // idle cycles freeze the address
  holdWithoutStep: assert property (@(posedge clk) disable iff (reset)
    !step |=> $stable(currentAddress))
    else $error("instruction address moved without a step");

endmodule : programCounter

`default_nettype wire

//--- source/flowUnit.sv
`timescale 1ns/1ps
`default_nettype none

// control-flow block of the rv32i core
// decoder and comparator run in parallel, counter combines them
module flowUnit import flowPkg::*; #(
  parameter addressT resetVector = '0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  input  logic [31:0] instruction,
  input  operandT     operands,
  output resultT      result
);

  // kind, immediate and funct3 of the current instruction
  decodeT decode;
  // comparator verdict, only looked at for branches
  logic   branchTaken;

  immediateDecoder u_decoder (
    .instruction (instruction),
    .decode      (decode)
  );

  // funct3 taken from the decoder so both consumers agree
  branchComparator u_comparator (
    .funct3      (decode.funct3),
    .operands    (operands),
    .branchTaken (branchTaken)
  );

  programCounter #(
    .resetVector (resetVector)
  ) u_counter (
    .clk         (clk),
    .reset       (reset),
    .step        (step),
    .decode      (decode),
    .branchTaken (branchTaken),
    // only rs1 is a jump base, rs2 goes to the comparator alone
    .rs1Value    (operands.rs1Value),
    .result      (result)
  );

endmodule : flowUnit

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock and power-on reset
module clockGen (
  output logic clk,
  output logic reset
);

  // 4 ns period
  localparam int halfPeriod  = 2;
  localparam int resetCycles = 2;

  initial begin
    clk = 1'b0;
    forever begin
      #halfPeriod clk = ~clk;
    end
  end

  // held over the first rising edges, dropped on a falling edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) begin
      @(posedge clk);
    end
    @(negedge clk);
    reset = 1'b0;
  end

endmodule : clockGen

`default_nettype wire

//--- bench/flowUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the rv32i control-flow block
module flowUnitTb import flowPkg::*; ();

  localparam addressT resetVector = 32'h0000_1000;

  // steps per test
  localparam int seqSteps    = 24;
  localparam int jumpSteps   = 48;
  localparam int branchSteps = 96;
  localparam int auipcSteps  = 16;
  localparam int mixSteps    = 600;
  localparam int totalSteps  = seqSteps + jumpSteps + branchSteps + auipcSteps + mixSteps;

  // timing in ns
  localparam int clockPeriod = 4;
  localparam int resetTime   = 3 * clockPeriod;

  // what one instruction should produce
  typedef struct packed {
    resultT  result;
    addressT nextAddress;
  } expectT;

  logic        clk;
  logic        reset;
  logic        step;
  logic [31:0] instruction;
  operandT     operands;
  resultT      result;

  // model state, advanced by the compare process
  addressT modelAddress;
  // expectation for the step on the inputs right now
  expectT  expectedNow;

  int errorCount;
  int checkCount;
  int stepCount;

  clockGen u_clock (
    .clk   (clk),
    .reset (reset)
  );

  flowUnit #(
    .resetVector (resetVector)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .step        (step),
    .instruction (instruction),
    .operands    (operands),
    .result      (result)
  );

  // expected result and next address straight from the rv32i rules
  function automatic expectT referenceStep(addressT address, logic [31:0] word, operandT ops);
    expectT  e;
    addressT offset;
    addressT plusFour;
    logic    taken;
    plusFour = address + instructionStep;
    e.result.instructionAddress = address;
    e.result.linkAddress = '0;
    e.result.linkValid = 1'b0;
    e.nextAddress = plusFour;
    case (word[6:0])
      7'b1101111: begin
        // jal, 21-bit signed offset
        offset = 32'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
        e.nextAddress = address + offset;
        e.result.linkAddress = plusFour;
        e.result.linkValid = 1'b1;
      end
      7'b1100111: begin
        // jalr, 12-bit offset from rs1
        offset = 32'($signed(word[31:20]));
        e.nextAddress = (ops.rs1Value + offset) & ~32'h1;
        e.result.linkAddress = plusFour;
        e.result.linkValid = 1'b1;
      end
      7'b1100011: begin
        offset = 32'($signed({word[31], word[7], word[30:25], word[11:8], 1'b0}));
        case (word[14:12])
          3'b000:  taken = ops.rs1Value == ops.rs2Value;
          3'b001:  taken = ops.rs1Value != ops.rs2Value;
          3'b100:  taken = $signed(ops.rs1Value) < $signed(ops.rs2Value);
          3'b101:  taken = $signed(ops.rs1Value) >= $signed(ops.rs2Value);
          3'b110:  taken = ops.rs1Value < ops.rs2Value;
          3'b111:  taken = ops.rs1Value >= ops.rs2Value;
          default: taken = 1'b0;
        endcase
        if (taken) begin
          e.nextAddress = address + offset;
        end
      end
      7'b0010111: begin
        // auipc, upper 20 bits onto the pc
        e.result.linkAddress = address + {word[31:12], 12'h000};
        e.result.linkValid = 1'b1;
      end
      default: begin
        // everything else just falls through
      end
    endcase
    return e;
  endfunction

  task automatic checkAddress(addressT actual, addressT expected, string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic checkResult(resultT actual, resultT expected);
    checkAddress(actual.instructionAddress, expected.instructionAddress, "instructionAddress");
    checkAddress(actual.linkAddress, expected.linkAddress, "linkAddress");
    checkCount++;
    if (actual.linkValid !== expected.linkValid) begin
      errorCount++;
      $display("Fail at %0t: linkValid is %b, expected %b", $time, actual.linkValid,
               expected.linkValid);
    end
  endtask

  // random word with the opcode of the wanted kind
  // kind 0 alu, 1 jal, 2 jalr, 3 branch, 4 auipc
  function automatic logic [31:0] makeInstruction(int kind, int branchCode);
    logic [31:0] bits;
    logic [2:0]  branchFunct3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    bits = $urandom;
    case (kind)
      0:       return {bits[31:7], 7'b0010011};
      1:       return {bits[31:7], 7'b1101111};
      2:       return {bits[31:15], 3'b000, bits[11:7], 7'b1100111};
      3:       return {bits[31:15], branchFunct3[branchCode], bits[11:7], 7'b1100011};
      default: return {bits[31:7], 7'b0010111};
    endcase
  endfunction

  // operand pairs, with equal and sign-boundary cases mixed in
  function automatic operandT makeOperands();
    operandT ops;
    case ($urandom_range(5))
      0: begin
        ops.rs1Value = $urandom;
        ops.rs2Value = ops.rs1Value;
      end
      1: ops = '{rs1Value: 32'h7fff_ffff, rs2Value: 32'h8000_0000};
      2: ops = '{rs1Value: 32'h8000_0000, rs2Value: 32'h7fff_ffff};
      3: ops = '{rs1Value: 32'h0000_0000, rs2Value: 32'hffff_ffff};
      default: begin
        ops.rs1Value = $urandom;
        ops.rs2Value = $urandom;
      end
    endcase
    return ops;
  endfunction

  // one step on the next falling edge
  task automatic driveStep(logic [31:0] word, operandT ops);
    @(negedge clk);
    instruction = word;
    operands = ops;
    expectedNow = referenceStep(modelAddress, word, ops);
    step = 1'b1;
    stepCount++;
  endtask

  task automatic driveIdle(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      step = 1'b0;
    end
  endtask

  // waits an edge so the last address check belongs to this test
  task automatic reportTest(string name, int firstError);
    @(posedge clk);
    $display("test %s done, %0d errors", name, errorCount - firstError);
  endtask

  // compare, mid low phase, inputs settled since the falling edge
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (!reset) begin
        if (step) begin
          checkResult(result, expectedNow.result);
          modelAddress = expectedNow.nextAddress;
        end else begin
          checkAddress(result.instructionAddress, modelAddress, "instructionAddress");
        end
      end
    end
  end

  // stimulus
  initial begin
    int     firstError;
    resultT afterReset;
    void'($urandom(32'haac9_ead6));
    step = 1'b0;
    // addi x0, x0, 0
    instruction = 32'h0000_0013;
    operands = '0;
    modelAddress = resetVector;
    expectedNow = '0;
    errorCount = 0;
    checkCount = 0;
    stepCount = 0;
    wait (reset == 1'b0);
    @(negedge clk);

    firstError = errorCount;
    afterReset = '{instructionAddress: resetVector, linkAddress: '0, linkValid: 1'b0};
    checkResult(result, afterReset);
    reportTest("reset", firstError);

    // idle pairs in between
    firstError = errorCount;
    for (int i = 0; i < seqSteps; i++) begin
      driveStep(makeInstruction(0, 0), makeOperands());
      if (i % 3 == 2) begin
        driveIdle(2);
      end
    end
    driveIdle(1);
    reportTest("sequential", firstError);

    // jal and jalr alternate
    firstError = errorCount;
    for (int i = 0; i < jumpSteps; i++) begin
      driveStep(makeInstruction(1 + i % 2, 0), makeOperands());
    end
    driveIdle(1);
    reportTest("jump", firstError);

    // all six conditions in turn
    firstError = errorCount;
    for (int i = 0; i < branchSteps; i++) begin
      driveStep(makeInstruction(3, i % 6), makeOperands());
    end
    driveIdle(1);
    reportTest("branch", firstError);

    firstError = errorCount;
    for (int i = 0; i < auipcSteps; i++) begin
      driveStep(makeInstruction(4, 0), makeOperands());
    end
    driveIdle(1);
    reportTest("auipc", firstError);

    // back-to-back random kinds
    firstError = errorCount;
    for (int i = 0; i < mixSteps; i++) begin
      driveStep(makeInstruction($urandom_range(4), $urandom_range(5)), makeOperands());
    end
    driveIdle(1);
    reportTest("mix", firstError);

    driveIdle(2);
    @(posedge clk);
    $display("checks %0d, errors %0d, steps %0d", checkCount, errorCount, stepCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // four clock periods per step is ample, idle cycles included
  initial begin
    #(totalSteps * clockPeriod * 4 + resetTime);
    $display("watchdog expired at %0t, the run did not reach its end", $time);
    $display("Test failed");
    $finish;
  end

endmodule : flowUnitTb

`default_nettype wire

//--- flowUnit.f
source/flowPkg.sv
source/immediateDecoder.sv
source/branchComparator.sv
source/programCounter.sv
source/flowUnit.sv
bench/clockGen.sv
bench/flowUnitTb.sv

//--- Bender.yml
package:
  name: flow_unit

sources:
  # package first, then leaves, then the top level
  - files:
      - source/flowPkg.sv
      - source/immediateDecoder.sv
      - source/branchComparator.sv
      - source/programCounter.sv
      - source/flowUnit.sv

  # testbench
  - target: test
    files:
      - bench/clockGen.sv
      - bench/flowUnitTb.sv
